//--- bench/tb_cmd_top.sv
// Register link testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cmd_top
	import cmd_pkg::*;
();

	logic       clk_sys;
	logic       rst_n;
	logic       uart_rxd;
	wire        uart_txd;
	wire        frame_drop;

	// reference copy of the register bank
	logic [7:0] ref_bank [REG_COUNT];
	logic [7:0] rsp_status;
	logic [7:0] rsp_rdata;
	int         rsp_count;
	int         exp_count;
	int         drop_count;
	int         err_count;
	int         chk_count;
	bit         drop_allowed;
	integer     seed;
	// upper bound of one reply after the last command byte
	int         reply_wait = 6 * 10 * CLKS_PER_BIT;
	int         frames_planned = 58;

	cmd_top uut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.uart_rxd   (uart_rxd),
		.uart_txd   (uart_txd),
		.frame_drop (frame_drop)
	);

	always #4 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		if (frame_drop)
			drop_count++;
	end

	task automatic report_err(input string msg);
		err_count++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// start, eight data bits lsb first, stop
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_sys);
			uart_rxd = bits[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk_sys);
		end
	endtask

	task automatic send_frame(input logic [7:0] dev, input logic [7:0] mode,
			input logic [7:0] addr, input logic [7:0] data);
		send_byte(dev);
		send_byte(mode);
		send_byte(addr);
		send_byte(data);
	endtask

	// samples each bit near its centre
	task automatic read_serial_byte(output logic [7:0] b);
		@(negedge clk_sys);
		while (uart_txd !== 1'b0)
			@(negedge clk_sys);
		repeat (CLKS_PER_BIT / 2) @(negedge clk_sys);
		assert (uart_txd === 1'b0)
			else report_err("start bit on uart_txd not held low");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk_sys);
			b[i] = uart_txd;
		end
		repeat (CLKS_PER_BIT) @(negedge clk_sys);
		assert (uart_txd === 1'b1)
			else report_err("stop bit on uart_txd is low");
	endtask

	// model update and expected reply, then one frame on the line
	task automatic run_cmd(input logic [7:0] mode, input logic [7:0] addr,
			input logic [7:0] data);
		status_t    exp_st;
		logic [7:0] exp_rd;
		int         prev;
		int         n;
		prev   = rsp_count;
		exp_rd = 8'h00;
		if (mode != OP_WRITE && mode != OP_READ && mode != OP_SET && mode != OP_CLEAR)
			exp_st = ST_BAD_OP;
		else if (addr >= REG_COUNT)
			exp_st = ST_BAD_ADDR;
		else
			exp_st = ST_OK;
		if (exp_st == ST_OK) begin
			case (mode)
				OP_WRITE: ref_bank[addr[3:0]] = data;
				OP_SET:   ref_bank[addr[3:0]] = ref_bank[addr[3:0]] | data;
				OP_CLEAR: ref_bank[addr[3:0]] = ref_bank[addr[3:0]] & ~data;
				default: ;
			endcase
			exp_rd = ref_bank[addr[3:0]];
		end
		send_frame(DEV_ID, mode, addr, data);
		exp_count++;
		n = 0;
		while (rsp_count == prev && n < reply_wait) begin
			@(negedge clk_sys);
			n++;
		end
		if (rsp_count == prev) begin
			err_count++;
			$display("no reply arrived for mode %h addr %h at %0t", mode, addr, $time);
		end else begin
			assert (rsp_status == exp_st && rsp_rdata == exp_rd) chk_count++;
			else report_err($sformatf("mode %h addr %h reply %h/%h expected %h/%h",
				mode, addr, rsp_status, rsp_rdata, exp_st, exp_rd));
		end
	endtask

	a_drop_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		frame_drop |=> !frame_drop)
		else report_err("frame_drop high for more than one cycle");

	a_drop_expected: assert property (@(posedge clk_sys) disable iff (!rst_n)
		frame_drop |-> drop_allowed)
		else report_err("frame_drop without a stalled frame");

	// reply collector, four bytes per frame
	initial begin
		logic [7:0] frame [4];
		wait (rst_n === 1'b1);
		forever begin
			for (int k = 0; k < 4; k++)
				read_serial_byte(frame[k]);
			assert (frame[0] == RSP_HEADER) chk_count++;
			else report_err($sformatf("reply header %h", frame[0]));
			assert (frame[3] == (frame[0] ^ frame[1] ^ frame[2])) chk_count++;
			else report_err($sformatf("reply checksum %h", frame[3]));
			rsp_status = frame[1];
			rsp_rdata  = frame[2];
			rsp_count++;
		end
	end

	initial begin
		repeat (frames_planned * 20 * 10 * CLKS_PER_BIT + 2 * FRAME_TIMEOUT)
			@(posedge clk_sys);
		$display("watchdog expired at %0t, the run hung", $time);
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [7:0] addr;
		logic [7:0] wr_addr [8];
		int         prev_rsp;
		int         prev_drop;
		int         n;
		clk_sys      = 1'b0;
		rst_n        = 1'b0;
		uart_rxd     = 1'b1;
		rsp_count    = 0;
		exp_count    = 0;
		drop_count   = 0;
		err_count    = 0;
		chk_count    = 0;
		drop_allowed = 1'b0;
		seed         = 32'h1770;
		for (int i = 0; i < REG_COUNT; i++)
			ref_bank[i] = 8'h00;
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;
		repeat (4) @(negedge clk_sys);

		// bank comes out of reset cleared
		for (int i = 0; i < REG_COUNT; i++)
			run_cmd(OP_READ, 8'(i), 8'h00);

		for (int i = 0; i < 8; i++) begin
			wr_addr[i] = 8'($random(seed)) & 8'h0F;
			run_cmd(OP_WRITE, wr_addr[i], 8'($random(seed)));
		end
		for (int i = 0; i < 8; i++)
			run_cmd(OP_READ, wr_addr[i], 8'h00);

		// set and clear on registers that hold written values
		for (int i = 0; i < 4; i++) begin
			addr = wr_addr[i];
			run_cmd(OP_SET, addr, 8'($random(seed)));
			run_cmd(OP_READ, addr, 8'h00);
		end
		for (int i = 0; i < 4; i++) begin
			addr = wr_addr[i + 4];
			run_cmd(OP_CLEAR, addr, 8'($random(seed)));
			run_cmd(OP_READ, addr, 8'h00);
		end

		// rejected commands leave the bank alone
		addr = 8'($random(seed)) & 8'h0F;
		run_cmd(OP_WRITE, addr, 8'hC3);
		run_cmd(8'h07, addr, 8'h3C);
		run_cmd(OP_READ, addr, 8'h00);
		run_cmd(OP_WRITE, 8'h10 | addr, 8'h81);
		run_cmd(OP_READ, addr, 8'h00);
		run_cmd(8'h00, 8'h2F, 8'hFF);

		// foreign device byte, no reply expected
		prev_rsp = rsp_count;
		send_frame(8'hA3, OP_WRITE, addr, 8'h55);
		repeat (reply_wait) @(negedge clk_sys);
		assert (rsp_count == prev_rsp) chk_count++;
		else report_err("reply to a frame for another device");
		run_cmd(OP_READ, addr, 8'h00);

		// stalled frame after two bytes
		prev_rsp     = rsp_count;
		prev_drop    = drop_count;
		drop_allowed = 1'b1;
		send_byte(DEV_ID);
		send_byte(OP_READ);
		n = 0;
		while (drop_count == prev_drop && n < 2 * FRAME_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		repeat (4 * CLKS_PER_BIT) @(negedge clk_sys);
		assert (drop_count == prev_drop + 1 && rsp_count == prev_rsp) chk_count++;
		else report_err($sformatf("stall gave %0d drops and %0d replies",
			drop_count - prev_drop, rsp_count - prev_rsp));
		drop_allowed = 1'b0;
		run_cmd(OP_WRITE, addr, 8'($random(seed)));

		repeat (reply_wait) @(negedge clk_sys);
		assert (rsp_count == exp_count) chk_count++;
		else report_err($sformatf("%0d replies, expected %0d", rsp_count, exp_count));

		$display("replies %0d, drops %0d, passed checks %0d, errors %0d",
			rsp_count, drop_count, chk_count, err_count);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
source/cmd_pkg.sv
source/uart_rx.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/cmd_result.sv
source/uart_tx.sv
source/cmd_top.sv
bench/tb_cmd_top.sv

//--- source/cmd_decode.sv
// Command frame decoder
`timescale 1ns/1ns
`default_nettype none

module cmd_decode
	import cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        rx_vld,
	input  wire  [7:0] rx_data,
	output logic       cmd_vld,
	output cmd_t       cmd,
	output logic       frame_drop
);

	typedef enum logic [2:0] {
		D_IDLE,
		D_MODE,
		D_ADDR,
		D_DATA,
		D_FAIL,
		D_DONE
	} dec_state_t;

	dec_state_t             state;
	logic [TIMEOUT_W-1:0]   stall_cnt;
	logic                   timeout;
	logic                   in_frame;
	logic [7:0]             dev_q;
	logic [7:0]             mode_q;
	logic [7:0]             addr_q;
	logic [7:0]             data_q;
	logic                   op_known;

	assign in_frame = (state == D_MODE) || (state == D_ADDR) || (state == D_DATA);
	assign timeout  = (stall_cnt == FRAME_TIMEOUT);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= D_IDLE;
		end else begin
			case (state)
				D_IDLE: state <= rx_vld ? D_MODE : D_IDLE;
				D_MODE: state <= timeout ? D_FAIL : (rx_vld ? D_ADDR : D_MODE);
				D_ADDR: state <= timeout ? D_FAIL : (rx_vld ? D_DATA : D_ADDR);
				D_DATA: state <= timeout ? D_FAIL : (rx_vld ? D_DONE : D_DATA);
				D_FAIL: state <= D_IDLE;
				D_DONE: state <= D_IDLE;
				default: state <= D_IDLE;
			endcase
		end
	end

	// stall counter restarts on every byte of a partial frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			stall_cnt <= '0;
		else if (in_frame && !rx_vld)
			stall_cnt <= stall_cnt + 1'b1;
		else
			stall_cnt <= '0;
	end

	always_ff @(posedge clk_sys) begin
		if (rx_vld) begin
			case (state)
				D_IDLE: dev_q  <= rx_data;
				D_MODE: mode_q <= rx_data;
				D_ADDR: addr_q <= rx_data;
				D_DATA: data_q <= rx_data;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (mode_q)
			OP_WRITE, OP_READ, OP_SET, OP_CLEAR: op_known = 1'b1;
			default: op_known = 1'b0;
		endcase
	end

	// opcode fault takes priority over address fault
	always_comb begin
		cmd.op       = opcode_t'(mode_q);
		cmd.reg_addr = addr_q[3:0];
		cmd.wdata    = data_q;
		if (!op_known)
			cmd.status = ST_BAD_OP;
		else if (addr_q >= 8'(REG_COUNT))
			cmd.status = ST_BAD_ADDR;
		else
			cmd.status = ST_OK;
	end

	// frames for another device end here quietly
	assign cmd_vld    = (state == D_DONE) && (dev_q == DEV_ID);
	assign frame_drop = (state == D_FAIL);

	a_cmd_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_vld |=> !cmd_vld);

endmodule

`default_nettype wire

//--- source/cmd_execute.sv
// Register bank executor
`timescale 1ns/1ns
`default_nettype none

module cmd_execute
	import cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        cmd_vld,
	input  wire cmd_t  cmd,
	output logic       rsp_vld,
	output rsp_t       rsp
);

	logic [7:0] bank [REG_COUNT];
	logic [7:0] cur_val;
	logic [7:0] next_val;
	logic       cmd_ok;

	assign cmd_ok  = (cmd.status == ST_OK);
	assign cur_val = bank[cmd.reg_addr];

	// value after the operation, read leaves it alone
	always_comb begin
		case (cmd.op)
			OP_WRITE: next_val = cmd.wdata;
			OP_SET:   next_val = cur_val | cmd.wdata;
			OP_CLEAR: next_val = cur_val & ~cmd.wdata;
			default:  next_val = cur_val;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				bank[i] <= 8'h00;
			end
		end else if (cmd_vld && cmd_ok) begin
			bank[cmd.reg_addr] <= next_val;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			rsp_vld <= 1'b0;
		else
			rsp_vld <= cmd_vld;
	end

	// rejected commands report status with zero data
	always_ff @(posedge clk_sys) begin
		if (cmd_vld) begin
			rsp.status <= cmd.status;
			rsp.rdata  <= cmd_ok ? next_val : 8'h00;
		end
	end

	a_rsp_follows_cmd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_vld |-> $past(cmd_vld));

endmodule

`default_nettype wire

//--- source/cmd_pkg.sv
// Register link shared definitions
`default_nettype none

package cmd_pkg;

	// mode byte values
	typedef enum logic [7:0] {
		OP_WRITE = 8'h01,
		OP_READ  = 8'h02,
		OP_SET   = 8'h03,
		OP_CLEAR = 8'h04
	} opcode_t;

	typedef enum logic [7:0] {
		ST_OK       = 8'h00,
		ST_BAD_OP   = 8'h01,
		ST_BAD_ADDR = 8'h02
	} status_t;

	// decoded command, status is ST_OK only for a valid frame
	typedef struct packed {
		opcode_t    op;
		logic [3:0] reg_addr;
		logic [7:0] wdata;
		status_t    status;
	} cmd_t;

	typedef struct packed {
		status_t    status;
		logic [7:0] rdata;
	} rsp_t;

	// link identity and bank size
	localparam logic [7:0] DEV_ID = 8'h5A;
	localparam int REG_COUNT = 16;
	localparam logic [7:0] RSP_HEADER = 8'hA5;

	// serial bit timing
	localparam int CLKS_PER_BIT = 16;
	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CLK_CNT_W-1:0] BIT_LAST = CLK_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CLK_CNT_W-1:0] BIT_HALF = CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// stall limit between frame bytes
	localparam int TIMEOUT_W = 20;
	localparam logic [TIMEOUT_W-1:0] FRAME_TIMEOUT = TIMEOUT_W'(2000);

endpackage

`default_nettype wire

//--- source/cmd_result.sv
// Reply frame sender
`timescale 1ns/1ns
`default_nettype none

module cmd_result
	import cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        rsp_vld,
	input  wire rsp_t  rsp,
	input  wire        tx_busy,
	output logic       tx_start,
	output logic [7:0] tx_data
);

	// state names the byte currently on the line
	typedef enum logic [2:0] {
		B_IDLE,
		B_HDR,
		B_STAT,
		B_DATA,
		B_SUM
	} byte_idx_t;

	byte_idx_t  state;
	rsp_t       act;
	rsp_t       pend;
	logic       pend_vld;
	logic       busy_q;
	logic       busy_fall;
	logic       take_pend;
	logic       load_pend;
	logic [7:0] checksum;

	assign busy_fall = busy_q && !tx_busy;
	assign checksum  = RSP_HEADER ^ act.status ^ act.rdata;
	// slot drains straight into the next reply
	assign take_pend = pend_vld && ((state == B_IDLE) || ((state == B_SUM) && busy_fall));
	// full slot drops the new response
	assign load_pend = rsp_vld && ((state != B_IDLE) || pend_vld) && (!pend_vld || take_pend);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= B_IDLE;
			tx_start <= 1'b0;
			pend_vld <= 1'b0;
			busy_q   <= 1'b0;
		end else begin
			busy_q   <= tx_busy;
			tx_start <= 1'b0;
			case (state)
				B_IDLE: begin
					if (rsp_vld || pend_vld) begin
						tx_start <= 1'b1;
						state    <= B_HDR;
					end
				end
				B_HDR: begin
					if (busy_fall) begin
						tx_start <= 1'b1;
						state    <= B_STAT;
					end
				end
				B_STAT: begin
					if (busy_fall) begin
						tx_start <= 1'b1;
						state    <= B_DATA;
					end
				end
				B_DATA: begin
					if (busy_fall) begin
						tx_start <= 1'b1;
						state    <= B_SUM;
					end
				end
				B_SUM: begin
					if (busy_fall) begin
						tx_start <= pend_vld;
						state    <= pend_vld ? B_HDR : B_IDLE;
					end
				end
				default: state <= B_IDLE;
			endcase
			if (take_pend)
				pend_vld <= rsp_vld;
			else if (load_pend)
				pend_vld <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take_pend)
			act <= pend;
		else if (state == B_IDLE && rsp_vld)
			act <= rsp;
		if (load_pend)
			pend <= rsp;
	end

	always_comb begin
		case (state)
			B_STAT:  tx_data = act.status;
			B_DATA:  tx_data = act.rdata;
			B_SUM:   tx_data = checksum;
			default: tx_data = RSP_HEADER;
		endcase
	end

	a_start_when_free: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_start |-> !tx_busy);

endmodule

`default_nettype wire

//--- source/cmd_top.sv
// Serial register link top
`timescale 1ns/1ns
`default_nettype none

module cmd_top
	import cmd_pkg::*;
(
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  uart_rxd,
	output logic uart_txd,
	output logic frame_drop
);

	logic       rx_vld;
	logic [7:0] rx_data;
	logic       cmd_vld;
	cmd_t       cmd;
	logic       rsp_vld;
	rsp_t       rsp;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_busy;

	uart_rx u_uart_rx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.uart_rxd (uart_rxd),
		.rx_vld   (rx_vld),
		.rx_data  (rx_data)
	);

	cmd_decode u_cmd_decode (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rx_vld     (rx_vld),
		.rx_data    (rx_data),
		.cmd_vld    (cmd_vld),
		.cmd        (cmd),
		.frame_drop (frame_drop)
	);

	cmd_execute u_cmd_execute (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cmd_vld (cmd_vld),
		.cmd     (cmd),
		.rsp_vld (rsp_vld),
		.rsp     (rsp)
	);

	cmd_result u_cmd_result (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rsp_vld  (rsp_vld),
		.rsp      (rsp),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	uart_tx u_uart_tx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.uart_txd (uart_txd)
	);

endmodule

`default_nettype wire

//--- source/uart_rx.sv
// UART byte receiver
`timescale 1ns/1ns
`default_nettype none

module uart_rx
	import cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        uart_rxd,
	output logic       rx_vld,
	output logic [7:0] rx_data
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_START,
		R_DATA,
		R_STOP
	} rx_state_t;

	rx_state_t              state;
	logic                   rxd_meta;
	logic                   rxd_sync;
	logic [CLK_CNT_W-1:0]   clk_cnt;
	logic [2:0]             bit_cnt;

	// two-flop synchronizer, idles high
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= R_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				R_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_sync)
						state <= R_START;
				end
				// recheck start bit at its centre, reject glitches
				R_START: begin
					if (clk_cnt == BIT_HALF) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rxd_sync ? R_IDLE : R_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				R_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= R_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				// low stop bit means framing error, no strobe
				R_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						rx_vld <= rxd_sync;
						state  <= R_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk_sys) begin
		if (state == R_DATA && clk_cnt == BIT_LAST)
			rx_data <= {rxd_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// UART byte transmitter
`timescale 1ns/1ns
`default_nettype none

module uart_tx
	import cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        tx_start,
	input  wire  [7:0] tx_data,
	output logic       tx_busy,
	output logic       uart_txd
);

	// remaining bits after start, stop on top
	logic [8:0]             shift;
	logic [3:0]             bit_cnt;
	logic [CLK_CNT_W-1:0]   clk_cnt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy  <= 1'b0;
			uart_txd <= 1'b1;
			shift    <= '1;
			bit_cnt  <= '0;
			clk_cnt  <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy  <= 1'b1;
				uart_txd <= 1'b0;
				shift    <= {1'b1, tx_data};
				bit_cnt  <= '0;
				clk_cnt  <= '0;
			end
		end else if (clk_cnt == BIT_LAST) begin
			clk_cnt <= '0;
			// stop bit done, line already high
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				uart_txd <= shift[0];
				shift    <= {1'b1, shift[8:1]};
				bit_cnt  <= bit_cnt + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire
